// File: project.f
src/loader_pkg.sv
src/uart_rx.sv
src/word_assembler.sv
src/instr_mem.sv
src/program_loader.sv
test/program_loader_checker.sv
test/program_loader_tb.sv

// File: run.sh
#!/bin/sh
# Builds the program loader testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module program_loader_tb \
    -f project.f \
    -o program_loader_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit "$status"
fi

# Let bound assertion failures reach the testbench's final check.
./obj_dir/program_loader_sim +verilator+error+limit+100
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit "$status"
fi

echo "Simulation finished with status 0"
exit 0

// File: src/instr_mem.sv
`timescale 1ns/100ps

module instr_mem (
    input  logic                i_clock,
    input  loader_pkg::mem_wr_t i_mem_wr,
    input  loader_pkg::addr_t   i_read_addr,
    output loader_pkg::word_t   o_read_data
);

    import loader_pkg::*;

    word_t mem [MEM_DEPTH];

    // Single write port fed by the assembler.
    always_ff @(posedge i_clock) begin
        if (i_mem_wr.en) begin
            mem[i_mem_wr.addr] <= i_mem_wr.data;
        end
    end

    // Registered read, returns the old word on a same-edge write.
    always_ff @(posedge i_clock) begin
        o_read_data <= mem[i_read_addr];
    end

endmodule

// File: src/loader_pkg.sv
package loader_pkg;

    // Instruction word and UART byte sizes.
    localparam int WORD_BITS = 32;
    localparam int BYTE_BITS = 8;

    // Instruction memory geometry.
    localparam int MEM_DEPTH = 128;
    localparam int ADDR_BITS = $clog2(MEM_DEPTH);

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [ADDR_BITS-1:0] addr_t;

    // An all-ones word terminates the program.
    localparam word_t END_MARKER = '1;

    // One received byte with its single-cycle strobe.
    typedef struct packed {
        logic                 valid;
        logic [BYTE_BITS-1:0] data;
    } rx_byte_t;

    // One write into the instruction memory.
    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } mem_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } rx_state_t;

endpackage

// File: src/program_loader.sv
`timescale 1ns/100ps

module program_loader #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic              clock,
    input  logic              reset,
    input  logic              i_rx,
    input  loader_pkg::addr_t i_fetch_addr,
    output loader_pkg::word_t o_fetch_data,
    output logic              o_load_done,
    output logic              o_frame_error
);

    import loader_pkg::*;

    // Byte strobe from the receiver.
    rx_byte_t rx_byte;

    // Word writes into the instruction memory.
    mem_wr_t mem_wr;

    uart_rx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_rx_i (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_rx          (i_rx),
        .o_byte        (rx_byte),
        .o_frame_error (o_frame_error)
    );

    word_assembler word_assembler_i (
        .i_clock  (clock),
        .i_reset  (reset),
        .i_byte   (rx_byte),
        .o_mem_wr (mem_wr),
        .o_done   (o_load_done)
    );

    // Processor fetches go straight to the read port.
    instr_mem instr_mem_i (
        .i_clock     (clock),
        .i_mem_wr    (mem_wr),
        .i_read_addr (i_fetch_addr),
        .o_read_data (o_fetch_data)
    );

endmodule

// File: src/uart_rx.sv
`timescale 1ns/100ps

module uart_rx #(
    parameter int CLKS_PER_BIT = 16
) (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  logic                 i_rx,
    output loader_pkg::rx_byte_t o_byte,
    output logic                 o_frame_error
);

    import loader_pkg::*;

    // Baud counter sized for a full bit period.
    localparam int CNT_BITS = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_BITS-1:0] LAST_COUNT = CNT_BITS'(CLKS_PER_BIT - 1);
    localparam logic [CNT_BITS-1:0] HALF_COUNT = CNT_BITS'(CLKS_PER_BIT / 2 - 1);
    localparam logic [2:0] LAST_BIT = 3'(BYTE_BITS - 1);

    rx_state_t state;

    logic [CNT_BITS-1:0]  baud_count;
    logic [2:0]           bit_index;
    logic [BYTE_BITS-1:0] shift_reg;
    logic                 byte_valid;
    logic                 rx_meta;
    logic                 rx_sync;
    logic                 bit_tick;
    logic                 data_tick;

    // Two-flop synchronizer, line idles high.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    // Middle of a data or stop bit.
    assign bit_tick  = (baud_count == LAST_COUNT);
    assign data_tick = (state == DATA) && bit_tick;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state         <= IDLE;
            baud_count    <= '0;
            bit_index     <= '0;
            byte_valid    <= 1'b0;
            o_frame_error <= 1'b0;
        end else begin
            byte_valid    <= 1'b0;
            o_frame_error <= 1'b0;
            case (state)
                IDLE: begin
                    baud_count <= '0;
                    bit_index  <= '0;
                    if (!rx_sync) begin
                        state <= START;
                    end
                end
                START: begin
                    // Recheck the line at mid start bit to reject glitches.
                    if (baud_count == HALF_COUNT) begin
                        baud_count <= '0;
                        state      <= rx_sync ? IDLE : DATA;
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                DATA: begin
                    if (bit_tick) begin
                        baud_count <= '0;
                        bit_index  <= bit_index + 1'b1;
                        if (bit_index == LAST_BIT) begin
                            state <= STOP;
                        end
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                STOP: begin
                    // A low stop bit drops the byte and flags the error.
                    if (bit_tick) begin
                        baud_count    <= '0;
                        byte_valid    <= rx_sync;
                        o_frame_error <= !rx_sync;
                        state         <= IDLE;
                    end else begin
                        baud_count <= baud_count + 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first, so shift in from the top.
    always_ff @(posedge i_clock) begin
        if (data_tick) begin
            shift_reg <= {rx_sync, shift_reg[BYTE_BITS-1:1]};
        end
    end

    assign o_byte = '{valid: byte_valid, data: shift_reg};

endmodule

// File: src/word_assembler.sv
`timescale 1ns/100ps

module word_assembler (
    input  logic                 i_clock,
    input  logic                 i_reset,
    input  loader_pkg::rx_byte_t i_byte,
    output loader_pkg::mem_wr_t  o_mem_wr,
    output logic                 o_done
);

    import loader_pkg::*;

    localparam addr_t LAST_ADDR = ADDR_BITS'(MEM_DEPTH - 1);

    word_t      word_reg;
    word_t      next_word;
    addr_t      wr_addr;
    logic [1:0] byte_count;
    logic       accept;
    logic       last_byte;
    logic       mem_en;
    addr_t      mem_addr;
    word_t      mem_data;

    // Bytes are ignored once the load has finished.
    assign accept    = i_byte.valid && !o_done;
    assign last_byte = (byte_count == 2'd3);

    // New byte enters at the top so the first one ends up as the LSB.
    assign next_word = {i_byte.data, word_reg[WORD_BITS-1:BYTE_BITS]};

    always_ff @(posedge i_clock) begin
        if (accept) begin
            word_reg <= next_word;
        end
    end

    // Control path.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            byte_count <= '0;
            wr_addr    <= '0;
            o_done     <= 1'b0;
            mem_en     <= 1'b0;
        end else begin
            mem_en <= 1'b0;
            if (accept) begin
                byte_count <= byte_count + 1'b1;
                if (last_byte) begin
                    if (next_word == END_MARKER) begin
                        o_done <= 1'b1;
                    end else begin
                        mem_en  <= 1'b1;
                        wr_addr <= wr_addr + 1'b1;
                        // Memory full after this write.
                        if (wr_addr == LAST_ADDR) begin
                            o_done <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // The write payload is only meaningful while en is high.
    always_ff @(posedge i_clock) begin
        if (accept && last_byte) begin
            mem_addr <= wr_addr;
            mem_data <= next_word;
        end
    end

    assign o_mem_wr = '{en: mem_en, addr: mem_addr, data: mem_data};

endmodule

// File: test/program_loader_checker.sv
`timescale 1ns/100ps

module program_loader_checker (
    input logic                 i_clock,
    input logic                 i_reset,
    input loader_pkg::rx_byte_t i_rx_byte,
    input loader_pkg::mem_wr_t  i_mem_wr,
    input logic                 i_load_done,
    input logic                 i_frame_error
);

    // Number of failed assertions.
    int error_count = 0;

    // A frame is either accepted or rejected.
    strobe_exclusive: assert property (
        @(posedge i_clock) disable iff (i_reset)
        !(i_rx_byte.valid && i_frame_error)
    ) else begin
        $error("Byte valid and frame error high in the same cycle");
        error_count++;
    end

    // The full-memory write may coincide with done, later ones may not.
    no_write_after_done: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_load_done |=> !i_mem_wr.en
    ) else begin
        $error("Memory write enable while load done is high");
        error_count++;
    end

    // Frames are much longer than a cycle.
    single_byte_strobe: assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_rx_byte.valid |=> !i_rx_byte.valid
    ) else begin
        $error("Byte valid high on two consecutive cycles");
        error_count++;
    end

    done_holds: assert property (
        @(posedge i_clock)
        (i_load_done && !i_reset) |=> i_load_done
    ) else begin
        $error("Load done fell without a reset");
        error_count++;
    end

endmodule

// File: test/program_loader_tb.sv
`timescale 1ns/100ps

module program_loader_tb;

    import loader_pkg::*;

    localparam int CLKS_PER_BIT = 4;
    localparam int SEED = 48254;
    localparam int DONE_TIMEOUT = 20 * CLKS_PER_BIT;
    localparam int ERROR_TIMEOUT = 4 * CLKS_PER_BIT;

    logic  clock;
    logic  reset;
    logic  i_rx;
    addr_t i_fetch_addr;
    word_t o_fetch_data;
    logic  o_load_done;
    logic  o_frame_error;

    // Reference model of the memory and of the load state.
    word_t exp_mem [MEM_DEPTH];
    int    exp_addr;
    bit    exp_done;

    int    prog_len;
    int    k;

    program_loader #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) program_loader_i (
        .clock         (clock),
        .reset         (reset),
        .i_rx          (i_rx),
        .i_fetch_addr  (i_fetch_addr),
        .o_fetch_data  (o_fetch_data),
        .o_load_done   (o_load_done),
        .o_frame_error (o_frame_error)
    );

    bind program_loader program_loader_checker program_loader_checker_i (
        .i_clock       (clock),
        .i_reset       (reset),
        .i_rx_byte     (rx_byte),
        .i_mem_wr      (mem_wr),
        .i_load_done   (o_load_done),
        .i_frame_error (o_frame_error)
    );

    always #50 clock = ~clock;

    task automatic value_error(input string test, input word_t expected, input word_t actual);
        $display("ERROR %s: expected %h, actual %h", test, expected, actual);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // Stimulus changes a short time after each rising edge.
    task automatic next_cycle();
        @(posedge clock);
        #5;
    endtask

    task automatic hold_line(input logic level);
        i_rx = level;
        repeat (CLKS_PER_BIT) next_cycle();
    endtask

    task automatic send_frame(input logic [7:0] data, input bit bad_stop);
        int unsigned gap;
        logic [7:0]  bits;
        int          i;
        gap = $urandom_range(1, 12);
        bits = data;
        i_rx = 1'b1;
        repeat (gap) next_cycle();
        hold_line(1'b0);
        for (i = 0; i < 8; i++) begin
            hold_line(bits[0]);
            bits = bits >> 1;
        end
        hold_line(!bad_stop);
        // Line returns to idle after the stop bit.
        i_rx = 1'b1;
    endtask

    task automatic expect_frame_error(input string test);
        int cycles;
        bit seen;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < ERROR_TIMEOUT) begin
            next_cycle();
            seen = o_frame_error;
            cycles++;
        end
        assert (seen)
            else abort_run($sformatf("Timeout in %s: no frame error pulse seen", test));
    endtask

    function automatic word_t random_word();
        word_t w;
        w = $urandom;
        while (w == END_MARKER) begin
            w = $urandom;
        end
        return w;
    endfunction

    // Memory model follows the load rules: marker ends, full memory ends.
    function automatic void model_word(input word_t w);
        if (!exp_done) begin
            if (w == END_MARKER) begin
                exp_done = 1'b1;
            end else begin
                exp_mem[addr_t'(exp_addr)] = w;
                exp_addr++;
                if (exp_addr == MEM_DEPTH) begin
                    exp_done = 1'b1;
                end
            end
        end
    endfunction

    task automatic send_word(input word_t w, input bit inject_error, input string test);
        int unsigned bad_slot;
        word_t       rest;
        int          i;
        bad_slot = $urandom_range(0, 3);
        rest = w;
        for (i = 0; i < 4; i++) begin
            // A corrupted frame in between must not disturb assembly.
            if (inject_error && bad_slot == i) begin
                send_frame(8'($urandom), 1'b1);
                expect_frame_error(test);
            end
            send_frame(rest[7:0], 1'b0);
            rest = rest >> 8;
        end
        model_word(w);
    endtask

    task automatic check_done_level(input string test);
        assert (o_load_done === exp_done)
            else value_error(test, word_t'(exp_done), word_t'(o_load_done));
    endtask

    task automatic wait_done(input string test);
        int cycles;
        cycles = 0;
        while (!o_load_done && cycles < DONE_TIMEOUT) begin
            next_cycle();
            cycles++;
        end
        assert (o_load_done)
            else abort_run($sformatf("Timeout in %s: load done never rose", test));
        // Last write lands one edge after done and is readable one edge later.
        repeat (2) next_cycle();
    endtask

    task automatic apply_reset();
        reset = 1'b1;
        repeat (10) next_cycle();
        reset = 1'b0;
        exp_addr = 0;
        exp_done = 1'b0;
        check_done_level("reset");
        assert (o_frame_error === 1'b0)
            else value_error("reset", '0, word_t'(o_frame_error));
    endtask

    task automatic load_program(input string test, input int length, input bit with_marker,
                                input bit inject_errors);
        bit inject;
        int i;
        for (i = 0; i < length; i++) begin
            check_done_level(test);
            inject = inject_errors && (i == 0 || $urandom_range(0, 5) == 0);
            send_word(random_word(), inject, test);
        end
        if (with_marker) begin
            send_word(END_MARKER, 1'b0, test);
        end
        wait_done(test);
        check_done_level(test);
    endtask

    // Back-to-back fetches, each checked one cycle after its address.
    task automatic check_reads(input string test, input int count, input bit random_addr);
        addr_t prev_addr;
        addr_t next_addr;
        int    i;
        prev_addr = random_addr ? addr_t'($urandom) : '0;
        i_fetch_addr = prev_addr;
        for (i = 1; i <= count; i++) begin
            next_cycle();
            assert (o_fetch_data === exp_mem[prev_addr])
                else value_error($sformatf("%s addr %0d", test, prev_addr),
                                 exp_mem[prev_addr], o_fetch_data);
            next_addr = random_addr ? addr_t'($urandom) : addr_t'(i);
            i_fetch_addr = next_addr;
            prev_addr = next_addr;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clock = 1'b0;
        reset = 1'b1;
        i_rx = 1'b1;
        i_fetch_addr = '0;
        exp_addr = 0;
        exp_done = 1'b0;

        // Fill all 128 words with no marker.
        apply_reset();
        load_program("full_load", MEM_DEPTH, 1'b0, 1'b0);
        check_reads("full_load_readback", MEM_DEPTH, 1'b0);

        // Short program ending in a marker, with corrupted frames mixed in.
        apply_reset();
        prog_len = $urandom_range(1, 60);
        load_program("short_program", prog_len, 1'b1, 1'b1);
        check_reads("short_program_readback", MEM_DEPTH, 1'b0);

        // Words after done are dropped.
        for (k = 0; k < 3; k++) begin
            send_word(random_word(), 1'b0, "after_done");
        end
        repeat (2 * CLKS_PER_BIT) next_cycle();
        check_done_level("after_done");
        check_reads("after_done_readback", MEM_DEPTH, 1'b0);

        check_reads("random_fetch", 64, 1'b1);

        if (program_loader_i.program_loader_checker_i.error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Bound assertions failed %0d times",
                     program_loader_i.program_loader_checker_i.error_count);
            $display("=== FAIL ===");
            $fatal(1);
        end
    end

endmodule
